//--- project.f
hw/sk_encode_pkg.sv
hw/sk_coeff_mem.sv
hw/sk_fetch.sv
hw/sk_eta_encode.sv
hw/sk_pack.sv
hw/sk_encode_ctrl.sv
hw/sk_encode_top.sv
bench/sk_encode_assert.sv
bench/sk_encode_tb.sv

//--- Makefile
# Verilator build and run of the secret-key encoder testbench.

TOP := sk_encode_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/sk_encode_tb.sv
`timescale 1ns/10ps
`default_nettype none

module sk_encode_tb
    import sk_encode_pkg::*;
();

    localparam int ADDR_WIDTH       = 12;
    localparam int MLDSA_N          = 32;
    localparam int POLY_COUNT       = 3;
    localparam int GROUP_FIFO_DEPTH = 4;
    localparam int KEY_CREDITS      = 2;
    localparam int TOTAL_ROWS       = MLDSA_N * POLY_COUNT / ROW_COEFFS;
    localparam int TOTAL_WORDS      = MLDSA_N * POLY_COUNT * ETA_BITS / WORD_WIDTH;
    localparam int CLK_PERIOD       = 40;
    localparam int DRIVE_DELAY      = 2;
    localparam int RESET_CYCLES     = 3;
    localparam int NUM_RUNS         = 6;
    localparam int RUN_TIMEOUT      = 400;
    localparam int WATCHDOG_NS      = NUM_RUNS * TOTAL_WORDS * 8 * CLK_PERIOD
                                    + NUM_RUNS * (TOTAL_ROWS + 64) * CLK_PERIOD;

    logic                  clk;
    logic                  reset_n;
    logic                  start;
    logic [ADDR_WIDTH-1:0] src_base_addr;
    logic [ADDR_WIDTH-1:0] dest_base_addr;
    logic                  load_en;
    logic [ADDR_WIDTH-1:0] load_addr;
    coeff_row_t            load_row;
    logic                  key_credit;
    logic                  key_wr_en;
    logic [ADDR_WIDTH-1:0] key_wr_addr;
    key_word_t             key_wr_data;
    logic                  busy;
    logic                  done;
    logic                  error;

    // Host view of the coefficient memory, used by the reference.
    coeff_row_t row_model [2**ADDR_WIDTH];
    integer     seed = 68;
    int         error_count = 0;
    int         check_count = 0;
    int         cycle_no = 0;
    int         outstanding = 0;
    int         word_idx = 0;
    int         done_count = 0;
    int         last_write_cycle = 0;
    int         run_src = 0;
    int         run_dest = 0;
    int         credit_max_delay = 5;
    bit         run_active = 1'b0;
    string      test_name = "reset";
    int         credit_due [$];

    sk_encode_top #(
        .ADDR_WIDTH       (ADDR_WIDTH),
        .MLDSA_N          (MLDSA_N),
        .POLY_COUNT       (POLY_COUNT),
        .GROUP_FIFO_DEPTH (GROUP_FIFO_DEPTH),
        .KEY_CREDITS      (KEY_CREDITS)
    ) sk_encode_top_inst (
        .clk, .reset_n, .start, .src_base_addr, .dest_base_addr,
        .load_en, .load_addr, .load_row, .key_credit,
        .key_wr_en, .key_wr_addr, .key_wr_data, .busy, .done, .error
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_no <= cycle_no + 1;
    end

    // ==============================
    // Reference model
    // ==============================

    // The code is (2 - coeff) mod q, so small values wrap around by q.
    function automatic logic [ETA_BITS-1:0] eta_code(input logic [COEFF_WIDTH-1:0] coeff);
        int value;
        value = 2 - int'(coeff);
        if (value < 0) begin
            value = value + int'(MLDSA_Q);
        end
        return ETA_BITS'(value);
    endfunction

    // Codes form one little-endian bit stream, coefficient 0 at bit 0.
    function automatic key_word_t expected_word(input int src, input int index);
        key_word_t           word;
        int                  b;
        int                  pos;
        int                  coeff_idx;
        logic [ETA_BITS-1:0] code;
        word = '0;
        for (b = 0; b < WORD_WIDTH; b++) begin
            pos       = index * WORD_WIDTH + b;
            coeff_idx = pos / ETA_BITS;
            code      = eta_code(row_model[src + coeff_idx / ROW_COEFFS][coeff_idx % ROW_COEFFS]);
            word[b]   = code[pos % ETA_BITS];
        end
        return word;
    endfunction

    function automatic logic [COEFF_WIDTH-1:0] random_coeff();
        int pick;
        pick = {$random(seed)} % 5;
        case (pick)
            0:       return COEFF_WIDTH'(0);
            1:       return COEFF_WIDTH'(1);
            2:       return COEFF_WIDTH'(2);
            3:       return COEFF_WIDTH'(MLDSA_Q) - COEFF_WIDTH'(1);
            default: return COEFF_WIDTH'(MLDSA_Q) - COEFF_WIDTH'(2);
        endcase
    endfunction

    // ==============================
    // Compare tasks
    // ==============================

    task automatic check_word(input string name, input key_word_t exp, input key_word_t act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDR_WIDTH-1:0] exp,
                              input logic [ADDR_WIDTH-1:0] act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // ==============================
    // Key sink and compare process
    // ==============================

    // Each write schedules one credit, and the sink returns at most one per cycle.
    task automatic queue_credit();
        int due;
        due = cycle_no + 1 + ({$random(seed)} % (credit_max_delay + 1));
        if (credit_due.size() != 0 && due <= credit_due[$]) begin
            due = credit_due[$] + 1;
        end
        credit_due.push_back(due);
    endtask

    initial begin
        key_credit = 1'b0;
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (credit_due.size() != 0 && credit_due[0] <= cycle_no) begin
                key_credit = 1'b1;
                void'(credit_due.pop_front());
            end else begin
                key_credit = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (reset_n) begin
            if (key_wr_en) begin
                check_flag({test_name, " credit limit"}, 1'b1, outstanding < KEY_CREDITS);
                outstanding++;
                queue_credit();
                if (!run_active) begin
                    error_count++;
                    $display("Key write to address %h outside an active run", key_wr_addr);
                end else if (word_idx >= TOTAL_WORDS) begin
                    error_count++;
                    $display("More than %0d key writes in run %s", TOTAL_WORDS, test_name);
                end else begin
                    check_addr({test_name, " address"}, ADDR_WIDTH'(run_dest + word_idx),
                               key_wr_addr);
                    check_word({test_name, " data"}, expected_word(run_src, word_idx),
                               key_wr_data);
                end
                word_idx++;
                last_write_cycle = cycle_no;
            end
            if (done) begin
                done_count++;
                check_flag({test_name, " done after last write"}, 1'b1,
                           word_idx == TOTAL_WORDS && last_write_cycle == cycle_no - 1);
                run_active = 1'b0;
            end
            if (error && run_active) begin
                run_active = 1'b0;
            end
            if (key_credit) begin
                outstanding--;
            end
        end
    end

    // ==============================
    // Stimulus tasks
    // ==============================

    task automatic drive_row(input int addr, input coeff_row_t row);
        @(posedge clk);
        #DRIVE_DELAY;
        load_en   = 1'b1;
        load_addr = ADDR_WIDTH'(addr);
        load_row  = row;
        row_model[addr] = row;
    endtask

    task automatic release_load();
        @(posedge clk);
        #DRIVE_DELAY;
        load_en = 1'b0;
    endtask

    task automatic load_rows(input int base);
        coeff_row_t row;
        int         r;
        int         c;
        for (r = 0; r < TOTAL_ROWS; r++) begin
            for (c = 0; c < ROW_COEFFS; c++) begin
                row[c] = random_coeff();
            end
            drive_row(base + r, row);
        end
        release_load();
    endtask

    task automatic plant_coeff(input int addr, input int pos, input logic [COEFF_WIDTH-1:0] value);
        coeff_row_t row;
        row      = row_model[addr];
        row[pos] = value;
        drive_row(addr, row);
        release_load();
    endtask

    // One run from start to the end of credit return, with the closing checks.
    task automatic run_encode(input string name, input int src, input int dest,
                              input int max_delay, input bit expect_error, input bit move_bases);
        int cycles;
        test_name        = name;
        run_src          = src;
        run_dest         = dest;
        credit_max_delay = max_delay;
        word_idx         = 0;
        done_count       = 0;
        @(posedge clk);
        #DRIVE_DELAY;
        start          = 1'b1;
        src_base_addr  = ADDR_WIDTH'(src);
        dest_base_addr = ADDR_WIDTH'(dest);
        @(posedge clk);
        #DRIVE_DELAY;
        start      = 1'b0;
        run_active = 1'b1;
        check_flag({name, " busy after start"}, 1'b1, busy);
        check_flag({name, " error cleared by start"}, 1'b0, error);
        cycles = 0;
        while (run_active && cycles < RUN_TIMEOUT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            cycles++;
            // A second start and new bases in mid-run must not touch this run.
            if (move_bases && cycles == 3) begin
                start          = 1'b1;
                src_base_addr  = ADDR_WIDTH'(src + 300);
                dest_base_addr = ADDR_WIDTH'(dest + 300);
            end else begin
                start = 1'b0;
            end
        end
        if (run_active) begin
            error_count++;
            $display("Run %s did not end within %0d cycles", name, RUN_TIMEOUT);
            run_active = 1'b0;
        end
        cycles = 0;
        while ((cycles < 10 || outstanding != 0) && cycles < 64) begin
            @(posedge clk);
            cycles++;
        end
        #DRIVE_DELAY;
        if (expect_error) begin
            check_flag({name, " error raised"}, 1'b1, error);
            check_flag({name, " no done pulse"}, 1'b0, done_count != 0);
            check_flag({name, " writes stopped"}, 1'b1, word_idx <= 3);
        end else begin
            check_flag({name, " one done pulse"}, 1'b1, done_count == 1);
            check_flag({name, " all words written"}, 1'b1, word_idx == TOTAL_WORDS);
            check_flag({name, " error low"}, 1'b0, error);
        end
        check_flag({name, " busy low"}, 1'b0, busy);
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial begin
        clk            = 1'b0;
        reset_n        = 1'b0;
        start          = 1'b0;
        src_base_addr  = '0;
        dest_base_addr = '0;
        load_en        = 1'b0;
        load_addr      = '0;
        load_row       = '0;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
        end
        #DRIVE_DELAY;
        reset_n = 1'b1;
        check_flag("reset key_wr_en", 1'b0, key_wr_en);
        check_flag("reset done", 1'b0, done);
        check_flag("reset error", 1'b0, error);
        check_flag("reset busy", 1'b0, busy);

        load_rows(16);
        run_encode("full_encode", 16, 256, 5, 1'b0, 1'b0);
        run_encode("back_pressure", 16, 512, 12, 1'b0, 1'b0);

        load_rows(64);
        plant_coeff(64 + 10, 2, COEFF_WIDTH'(3));
        run_encode("invalid_coeff", 64, 768, 5, 1'b1, 1'b0);
        load_rows(64);
        run_encode("after_error", 64, 768, 5, 1'b0, 1'b0);

        run_encode("address_lock", 16, 1024, 5, 1'b0, 1'b1);
        load_rows(160);
        run_encode("other_bases", 160, 1536, 5, 1'b0, 1'b0);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns with the test sequence still running",
                 WATCHDOG_NS);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/sk_encode_assert.sv
`timescale 1ns/10ps
`default_nettype none

module sk_encode_assert #(
    parameter int GROUP_FIFO_DEPTH = 4,
    parameter int KEY_CREDITS      = 2
) (
    input wire                                    clk,
    input wire                                    reset_n,
    input wire                                    push,
    input wire                                    pop,
    input wire [$clog2(GROUP_FIFO_DEPTH + 1)-1:0] fifo_count,
    input wire                                    key_wr_en,
    input wire                                    key_credit,
    input wire                                    done,
    input wire                                    error
);

    int sink_credits;

    // Sink credits as seen at the pins, kept apart from the counter in sk_pack.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sink_credits <= KEY_CREDITS;
        end else begin
            sink_credits <= sink_credits + int'(key_credit) - int'(key_wr_en);
        end
    end

    // A write spends a sink credit, so one must be held.
    key_credit_held: assert property (@(posedge clk) disable iff (!reset_n)
        key_wr_en |-> (sink_credits > 0))
        else $error("key write issued with no sink credit");

    // A push into a full FIFO is only safe when a pop frees a slot.
    fifo_no_overflow: assert property (@(posedge clk) disable iff (!reset_n)
        push |-> (pop || fifo_count != ($clog2(GROUP_FIFO_DEPTH + 1))'(GROUP_FIFO_DEPTH)))
        else $error("group FIFO overflow");

    done_error_apart: assert property (@(posedge clk) disable iff (!reset_n)
        !(done && error))
        else $error("done and error high together");

    done_single_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        done |=> !done)
        else $error("done high for two cycles");

endmodule

bind sk_pack sk_encode_assert #(
    .GROUP_FIFO_DEPTH (GROUP_FIFO_DEPTH),
    .KEY_CREDITS      (KEY_CREDITS)
) sk_pack_assert_inst (
    .clk, .reset_n, .push, .pop, .fifo_count, .key_wr_en, .key_credit,
    .done (1'b0), .error (1'b0)
);

bind sk_encode_ctrl sk_encode_assert sk_ctrl_assert_inst (
    .clk, .reset_n, .push (1'b0), .pop (1'b0), .fifo_count ('0),
    .key_wr_en (1'b0), .key_credit (1'b0), .done, .error
);

`default_nettype wire

//--- hw/sk_encode_top.sv
`timescale 1ns/10ps
`default_nettype none

module sk_encode_top
    import sk_encode_pkg::*;
#(
    parameter int ADDR_WIDTH       = 12,
    parameter int MLDSA_N          = 256,
    parameter int POLY_COUNT       = 15,
    parameter int GROUP_FIFO_DEPTH = 4,
    parameter int KEY_CREDITS      = 2
) (
    input  wire                   clk,
    input  wire                   reset_n,
    input  wire                   start,
    input  wire  [ADDR_WIDTH-1:0] src_base_addr,
    input  wire  [ADDR_WIDTH-1:0] dest_base_addr,
    input  wire                   load_en,
    input  wire  [ADDR_WIDTH-1:0] load_addr,
    input  wire  coeff_row_t      load_row,
    input  wire                   key_credit,
    output logic                  key_wr_en,
    output logic [ADDR_WIDTH-1:0] key_wr_addr,
    output key_word_t             key_wr_data,
    output logic                  busy,
    output logic                  done,
    output logic                  error
);

    logic                  run;
    logic                  flush;
    logic [ADDR_WIDTH-1:0] src_base;
    logic [ADDR_WIDTH-1:0] dest_base;
    logic                  rd_en;
    logic [ADDR_WIDTH-1:0] rd_addr_a;
    logic [ADDR_WIDTH-1:0] rd_addr_b;
    coeff_row_t            rd_row_a;
    coeff_row_t            rd_row_b;
    logic                  rd_valid;
    logic                  group_valid;
    group_t                group_data;
    logic                  group_error;
    logic                  group_credit;
    logic                  word_written;

    // ==============================
    // Pipeline stages
    // ==============================

    sk_encode_ctrl #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .MLDSA_N    (MLDSA_N),
        .POLY_COUNT (POLY_COUNT)
    ) sk_encode_ctrl_inst (
        .clk, .reset_n, .start, .src_base_addr, .dest_base_addr,
        .group_valid, .group_error, .word_written,
        .run, .flush, .src_base, .dest_base, .busy, .done, .error
    );

    sk_fetch #(
        .ADDR_WIDTH       (ADDR_WIDTH),
        .MLDSA_N          (MLDSA_N),
        .POLY_COUNT       (POLY_COUNT),
        .GROUP_FIFO_DEPTH (GROUP_FIFO_DEPTH)
    ) sk_fetch_inst (
        .clk, .reset_n, .run, .flush, .src_base, .group_credit,
        .rd_en, .rd_addr_a, .rd_addr_b
    );

    sk_coeff_mem #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) sk_coeff_mem_inst (
        .clk, .reset_n, .load_en, .load_addr, .load_row,
        .rd_en, .rd_addr_a, .rd_addr_b, .rd_row_a, .rd_row_b, .rd_valid
    );

    sk_eta_encode sk_eta_encode_inst (
        .clk, .reset_n, .flush, .rd_valid, .rd_row_a, .rd_row_b,
        .group_valid, .group_data, .group_error
    );

    sk_pack #(
        .ADDR_WIDTH       (ADDR_WIDTH),
        .GROUP_FIFO_DEPTH (GROUP_FIFO_DEPTH),
        .KEY_CREDITS      (KEY_CREDITS)
    ) sk_pack_inst (
        .clk, .reset_n, .flush, .dest_base, .group_valid, .group_data, .key_credit,
        .group_credit, .key_wr_en, .key_wr_addr, .key_wr_data, .word_written
    );

endmodule

`default_nettype wire

//--- hw/sk_encode_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module sk_encode_ctrl
    import sk_encode_pkg::*;
#(
    parameter int ADDR_WIDTH = 12,
    parameter int MLDSA_N    = 256,
    parameter int POLY_COUNT = 15
) (
    input  wire                   clk,
    input  wire                   reset_n,
    input  wire                   start,
    input  wire  [ADDR_WIDTH-1:0] src_base_addr,
    input  wire  [ADDR_WIDTH-1:0] dest_base_addr,
    input  wire                   group_valid,
    input  wire                   group_error,
    input  wire                   word_written,
    output logic                  run,
    output logic                  flush,
    output logic [ADDR_WIDTH-1:0] src_base,
    output logic [ADDR_WIDTH-1:0] dest_base,
    output logic                  busy,
    output logic                  done,
    output logic                  error
);

    localparam int TOTAL_WORDS = MLDSA_N * POLY_COUNT * ETA_BITS / WORD_WIDTH;
    localparam int WCNT_W      = $clog2(TOTAL_WORDS + 1);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_RUN  = 2'd1;
    localparam logic [1:0] ST_DONE = 2'd2;

    logic [1:0]        state;
    logic [WCNT_W-1:0] word_cnt;
    logic              start_run;
    logic              abort;
    logic              last_word;

    assign start_run = (state == ST_IDLE) && start;
    assign abort     = (state == ST_RUN) && group_valid && group_error;
    assign last_word = word_written && (word_cnt == WCNT_W'(TOTAL_WORDS - 1));

    // Flush clears the pipeline before a run and throws away a failed one.
    assign flush = start_run || abort;
    assign run   = (state == ST_RUN);
    assign busy  = run;
    assign done  = (state == ST_DONE);

    always_ff @(posedge clk) begin
        if (start_run) begin
            src_base  <= src_base_addr;
            dest_base <= dest_base_addr;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= ST_IDLE;
            word_cnt <= '0;
            error    <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state    <= ST_RUN;
                        word_cnt <= '0;
                        error    <= 1'b0;
                    end
                end
                ST_RUN: begin
                    if (abort) begin
                        state <= ST_IDLE;
                        error <= 1'b1;
                    end else if (last_word) begin
                        state <= ST_DONE;
                    end else if (word_written) begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/sk_pack.sv
`timescale 1ns/10ps
`default_nettype none

module sk_pack
    import sk_encode_pkg::*;
#(
    parameter int ADDR_WIDTH       = 12,
    parameter int GROUP_FIFO_DEPTH = 4,
    parameter int KEY_CREDITS      = 2
) (
    input  wire                   clk,
    input  wire                   reset_n,
    input  wire                   flush,
    input  wire  [ADDR_WIDTH-1:0] dest_base,
    input  wire                   group_valid,
    input  wire  group_t          group_data,
    input  wire                   key_credit,
    output logic                  group_credit,
    output logic                  key_wr_en,
    output logic [ADDR_WIDTH-1:0] key_wr_addr,
    output key_word_t             key_wr_data,
    output logic                  word_written
);

    localparam int PTR_W   = (GROUP_FIFO_DEPTH > 1) ? $clog2(GROUP_FIFO_DEPTH) : 1;
    localparam int COUNT_W = $clog2(GROUP_FIFO_DEPTH + 1);
    localparam int KCRED_W = $clog2(KEY_CREDITS + 1);

    group_t                fifo_mem [GROUP_FIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [COUNT_W-1:0]    fifo_count;
    logic                  push;
    logic                  pop;
    sk_pack_buffer_t       pack_buf;
    logic [2:0]            fill_cnt;
    logic [1:0]            word_idx;
    logic                  draining;
    logic [KCRED_W-1:0]    key_credits;
    logic [ADDR_WIDTH-1:0] word_cnt;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(GROUP_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // ==============================
    // Fill and drain handshake
    // ==============================

    // The buffer takes groups until it is full, then gives up all three words.
    assign push     = group_valid && !flush;
    assign draining = (fill_cnt == 3'(GROUPS_PER_BUFFER));
    assign pop      = !flush && !draining && (fifo_count != '0);

    // Every group leaving the FIFO hands its slot back to the fetch stage.
    assign group_credit = pop;

    assign key_wr_en    = draining && !flush && (key_credits != '0);
    assign word_written = key_wr_en;
    assign key_wr_data  = pack_buf.words[word_idx];
    assign key_wr_addr  = dest_base + word_cnt;

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= group_data;
        end
        if (pop) begin
            pack_buf.groups[fill_cnt[1:0]] <= fifo_mem[rd_ptr];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
            fill_cnt   <= '0;
            word_idx   <= '0;
            word_cnt   <= '0;
        end else if (flush) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
            fill_cnt   <= '0;
            word_idx   <= '0;
            word_cnt   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, pop})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;
            endcase
            if (pop) begin
                fill_cnt <= fill_cnt + 1'b1;
            end else if (key_wr_en) begin
                word_cnt <= word_cnt + 1'b1;
                if (word_idx == 2'(WORDS_PER_BUFFER - 1)) begin
                    word_idx <= '0;
                    fill_cnt <= '0;
                end else begin
                    word_idx <= word_idx + 1'b1;
                end
            end
        end
    end

    // Sink credits are outstanding outside the design, so a flush keeps them.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            key_credits <= KCRED_W'(KEY_CREDITS);
        end else begin
            case ({key_credit, key_wr_en})
                2'b10:   key_credits <= key_credits + 1'b1;
                2'b01:   key_credits <= key_credits - 1'b1;
                default: key_credits <= key_credits;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/sk_eta_encode.sv
`timescale 1ns/10ps
`default_nettype none

module sk_eta_encode
    import sk_encode_pkg::*;
(
    input  wire        clk,
    input  wire        reset_n,
    input  wire        flush,
    input  wire        rd_valid,
    input  wire coeff_row_t rd_row_a,
    input  wire coeff_row_t rd_row_b,
    output logic       group_valid,
    output group_t     group_data,
    output logic       group_error
);

    logic [2*ROW_COEFFS-1:0][ETA_BITS-1:0] codes;
    logic [2*ROW_COEFFS-1:0]               bad;

    // Returns the invalid flag above the 3-bit code of (2 - coeff) mod q.
    function automatic logic [ETA_BITS:0] eta_map(input logic [COEFF_WIDTH-1:0] coeff);
        logic [ETA_BITS:0] res;
        case (coeff)
            COEFF_WIDTH'(0):              res = {1'b0, ETA_BITS'(2)};
            COEFF_WIDTH'(1):              res = {1'b0, ETA_BITS'(1)};
            COEFF_WIDTH'(2):              res = {1'b0, ETA_BITS'(0)};
            COEFF_WIDTH'(MLDSA_Q - 23'd1): res = {1'b0, ETA_BITS'(3)};
            COEFF_WIDTH'(MLDSA_Q - 23'd2): res = {1'b0, ETA_BITS'(4)};
            default:                      res = {1'b1, ETA_BITS'(0)};
        endcase
        return res;
    endfunction

    // Row a gives the low twelve bits of the group, row b the high twelve.
    always_comb begin
        for (int i = 0; i < ROW_COEFFS; i++) begin
            {bad[i], codes[i]} = eta_map(rd_row_a[i]);
            {bad[i + ROW_COEFFS], codes[i + ROW_COEFFS]} = eta_map(rd_row_b[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (rd_valid) begin
            group_data <= codes;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            group_valid <= 1'b0;
            group_error <= 1'b0;
        end else begin
            group_valid <= rd_valid && !flush;
            group_error <= rd_valid && !flush && (|bad);
        end
    end

endmodule

`default_nettype wire

//--- hw/sk_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module sk_fetch
    import sk_encode_pkg::*;
#(
    parameter int ADDR_WIDTH       = 12,
    parameter int MLDSA_N          = 256,
    parameter int POLY_COUNT       = 15,
    parameter int GROUP_FIFO_DEPTH = 4
) (
    input  wire                   clk,
    input  wire                   reset_n,
    input  wire                   run,
    input  wire                   flush,
    input  wire  [ADDR_WIDTH-1:0] src_base,
    input  wire                   group_credit,
    output logic                  rd_en,
    output logic [ADDR_WIDTH-1:0] rd_addr_a,
    output logic [ADDR_WIDTH-1:0] rd_addr_b
);

    localparam int TOTAL_ROWS  = MLDSA_N * POLY_COUNT / ROW_COEFFS;
    localparam int TOTAL_PAIRS = TOTAL_ROWS / 2;
    localparam int PAIR_W      = $clog2(TOTAL_PAIRS + 1);
    localparam int CREDIT_W    = $clog2(GROUP_FIFO_DEPTH + 1);

    logic [PAIR_W-1:0]   pair_cnt;
    logic [CREDIT_W-1:0] credits;
    logic                pairs_left;

    // A read pair goes out only while a FIFO slot is reserved for its group.
    assign pairs_left = (pair_cnt != PAIR_W'(TOTAL_PAIRS));
    assign rd_en      = run && !flush && pairs_left && (credits != '0);

    // Row a is the even row of the pair and row b the odd one.
    assign rd_addr_a = src_base + ADDR_WIDTH'({pair_cnt, 1'b0});
    assign rd_addr_b = rd_addr_a + ADDR_WIDTH'(1);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pair_cnt <= '0;
            credits  <= CREDIT_W'(GROUP_FIFO_DEPTH);
        end else if (flush) begin
            pair_cnt <= '0;
            credits  <= CREDIT_W'(GROUP_FIFO_DEPTH);
        end else begin
            if (rd_en) begin
                pair_cnt <= pair_cnt + 1'b1;
            end
            case ({rd_en, group_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/sk_coeff_mem.sv
`timescale 1ns/10ps
`default_nettype none

module sk_coeff_mem
    import sk_encode_pkg::*;
#(
    parameter int ADDR_WIDTH = 12
) (
    input  wire                  clk,
    input  wire                  reset_n,
    input  wire                  load_en,
    input  wire [ADDR_WIDTH-1:0] load_addr,
    input  wire coeff_row_t      load_row,
    input  wire                  rd_en,
    input  wire [ADDR_WIDTH-1:0] rd_addr_a,
    input  wire [ADDR_WIDTH-1:0] rd_addr_b,
    output coeff_row_t           rd_row_a,
    output coeff_row_t           rd_row_b,
    output logic                 rd_valid
);

    coeff_row_t mem [2**ADDR_WIDTH];

    // One write port from the host and two registered read ports.
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_row;
        end
        if (rd_en) begin
            rd_row_a <= mem[rd_addr_a];
            rd_row_b <= mem[rd_addr_b];
        end
    end

    // Read data is valid exactly one cycle after the request.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

endmodule

`default_nettype wire

//--- hw/sk_encode_pkg.sv
`default_nettype none

package sk_encode_pkg;

    // ==============================
    // ML-DSA constants and widths
    // ==============================

    localparam logic [22:0] MLDSA_Q = 23'd8380417;

    localparam int COEFF_WIDTH       = 24;
    localparam int ROW_COEFFS        = 4;
    localparam int ETA_BITS          = 3;
    localparam int GROUP_WIDTH       = 24;
    localparam int WORD_WIDTH        = 32;
    localparam int GROUPS_PER_BUFFER = 4;
    localparam int WORDS_PER_BUFFER  = 3;

    // ==============================
    // Data types
    // ==============================

    // Coefficient 0 sits in the lowest 24 bits of the row.
    typedef logic [ROW_COEFFS-1:0][COEFF_WIDTH-1:0] coeff_row_t;

    // Eight 3-bit codes, coefficient 0 lowest.
    typedef logic [GROUP_WIDTH-1:0] group_t;

    typedef logic [WORD_WIDTH-1:0] key_word_t;

    // The same 96 bits are filled as four groups and drained as three words.
    typedef union packed {
        group_t    [GROUPS_PER_BUFFER-1:0] groups;
        key_word_t [WORDS_PER_BUFFER-1:0]  words;
    } sk_pack_buffer_t;

endpackage

`default_nettype wire
